// File: monitor_cfg_pkg.sv
// Monitor-wide constants only; flag bit positions 0 to 3 must stay aligned with rv_trap_pkg kinds
`default_nettype none

package monitor_cfg_pkg;

  // Default PC width of the monitored core
  localparam int PC_WIDTH = 32;

  // Number of sticky error flags the monitor reports
  localparam int NUM_CHECKS = 7;

  // One bit per error flag, indexed by the CHK_* positions below
  typedef logic [NUM_CHECKS-1:0] check_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // Flag positions in check_vec_t
  ////////////////////////////////////////////////////////////////////////////

  // The four mepc flags share their index with the matching trap kind
  localparam int CHK_MEPC_ILLEGAL = 0;
  localparam int CHK_MEPC_ECALL   = 1;
  localparam int CHK_MEPC_EBREAK  = 2;
  localparam int CHK_MEPC_BUSERR  = 3;
  localparam int CHK_STEP         = 4;
  localparam int CHK_FETCH_BUF    = 5;
  localparam int CHK_LOAD_BUF     = 6;

  // Bus memtype field layout, bit 0 marks the access as bufferable
  localparam int MEMTYPE_WIDTH          = 2;
  localparam int MEMTYPE_BUFFERABLE_BIT = 0;

endpackage

`default_nettype wire

// File: rv_trap_pkg.sv
// RISC-V machine-mode trap encodings; only the four synchronous causes the monitor tracks
`default_nettype none

package rv_trap_pkg;

  // Trap kinds followed by the mepc checks, also used as vector indices
  typedef enum logic [1:0] {
    TRAP_ILLEGAL = 2'd0,
    TRAP_ECALL   = 2'd1,
    TRAP_EBREAK  = 2'd2,
    TRAP_BUSERR  = 2'd3
  } trap_kind_e;

  localparam int NUM_TRAP_KINDS = 4;

  // One bit per trap kind
  typedef logic [NUM_TRAP_KINDS-1:0] kind_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // mcause encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam int EXC_CODE_WIDTH = 11;
  localparam int IRQ_ID_WIDTH   = 5;

  // Exception codes from the privileged spec
  localparam logic [EXC_CODE_WIDTH-1:0] EXC_INSTR_BUS_FAULT = 11'd1;
  localparam logic [EXC_CODE_WIDTH-1:0] EXC_ILLEGAL_INSN    = 11'd2;
  localparam logic [EXC_CODE_WIDTH-1:0] EXC_BREAKPOINT      = 11'd3;
  localparam logic [EXC_CODE_WIDTH-1:0] EXC_ECALL_MMODE     = 11'd11;

  // The cause word seen as a synchronous exception
  typedef struct packed {
    logic                      interrupt;
    logic [EXC_CODE_WIDTH-1:0] exception_code;
  } exc_view_t;

  // The same word seen as an interrupt, upper id bits are unused
  typedef struct packed {
    logic                    interrupt;
    logic [5:0]              unused;
    logic [IRQ_ID_WIDTH-1:0] irq_id;
  } irq_view_t;

  // 12-bit cause word written by the controller at a cause save
  typedef union packed {
    exc_view_t exc;
    irq_view_t irq;
  } trap_cause_u;

endpackage

`default_nettype wire

// File: wb_trap_tracker.sv
// Captures only the first writeback of each trap kind; later traps of that kind are not tracked
`timescale 1ns/1ns
`default_nettype none

module wb_trap_tracker #(
  parameter int PC_W = monitor_cfg_pkg::PC_WIDTH
) (
  input  wire logic                                         clk,
  input  wire logic                                         rst_ni,
  input  wire logic                                         wb_valid_i,
  input  wire logic [PC_W-1:0]                              wb_pc_i,
  input  wire logic                                         wb_illegal_i,
  input  wire logic                                         wb_ecall_i,
  input  wire logic                                         wb_ebrk_i,
  input  wire logic                                         wb_bus_err_i,
  input  wire logic                                         irq_ack_i,
  input  wire logic                                         debug_req_i,
  input  wire logic                                         nmi_trap_i,
  input  wire logic                                         debug_entry_i,
  output rv_trap_pkg::kind_vec_t                            found_o,
  output logic [rv_trap_pkg::NUM_TRAP_KINDS-1:0][PC_W-1:0]  pc_o
);

  import rv_trap_pkg::*;

  logic                                 wb_ok;
  kind_vec_t                            hit;
  kind_vec_t                            capture;
  kind_vec_t                            found_q;
  logic [NUM_TRAP_KINDS-1:0][PC_W-1:0]  pc_q;

  // A retiring instruction only traps if no interrupt, debug request or NMI wins the cycle
  assign wb_ok = wb_valid_i && !irq_ack_i && !debug_req_i && !nmi_trap_i;

  // Priority is bus error, illegal, ecall, ebreak
  // An instruction heading into debug mode does not trap, except for EBREAK which causes that entry
  always_comb begin
    hit               = '0;
    hit[TRAP_BUSERR]  = wb_ok && wb_bus_err_i && !debug_entry_i;
    hit[TRAP_ILLEGAL] = wb_ok && wb_illegal_i && !wb_bus_err_i && !debug_entry_i;
    hit[TRAP_ECALL]   = wb_ok && wb_ecall_i && !wb_bus_err_i && !wb_illegal_i && !debug_entry_i;
    hit[TRAP_EBREAK]  = wb_ok && wb_ebrk_i && !wb_bus_err_i && !wb_illegal_i && !wb_ecall_i;
  end

  // Only the first hit of a kind is kept
  assign capture = hit & ~found_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | capture;
    end
  end

  // PC payload, meaningful only once the matching found bit is set
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_TRAP_KINDS; k++) begin
      if (capture[k]) begin
        pc_q[k] <= wb_pc_i;
      end
    end
  end

  assign found_o = found_q;
  assign pc_o    = pc_q;

  // The checker relies on each capture staying put until reset
  a_found_sticky : assert property (@(posedge clk) disable iff (!rst_ni)
    (($past(found_q) & ~found_q) == '0))
    else $error("wb_trap_tracker: found bit cleared");

endmodule

`default_nettype wire

// File: cause_save_tracker.sv
// Expects csr_cause_i and mepc_n_i valid in the csr_save_cause_i cycle; interrupt saves are ignored
`timescale 1ns/1ns
`default_nettype none

module cause_save_tracker #(
  parameter int PC_W = monitor_cfg_pkg::PC_WIDTH
) (
  input  wire logic                                         clk,
  input  wire logic                                         rst_ni,
  input  wire logic                                         csr_save_cause_i,
  input  wire rv_trap_pkg::trap_cause_u                     csr_cause_i,
  input  wire logic [PC_W-1:0]                              mepc_n_i,
  output rv_trap_pkg::kind_vec_t                            found_o,
  output logic [rv_trap_pkg::NUM_TRAP_KINDS-1:0][PC_W-1:0]  pc_o
);

  import rv_trap_pkg::*;

  kind_vec_t                            save_hit;
  kind_vec_t                            capture;
  kind_vec_t                            found_q;
  logic [NUM_TRAP_KINDS-1:0][PC_W-1:0]  pc_q;

  // Map the exception code of a synchronous save onto a trap kind
  // Codes outside the tracked four leave every bit clear
  always_comb begin
    save_hit = '0;
    if (csr_save_cause_i && !csr_cause_i.exc.interrupt) begin
      case (csr_cause_i.exc.exception_code)
        EXC_ILLEGAL_INSN:    save_hit[TRAP_ILLEGAL] = 1'b1;
        EXC_ECALL_MMODE:     save_hit[TRAP_ECALL]   = 1'b1;
        EXC_BREAKPOINT:      save_hit[TRAP_EBREAK]  = 1'b1;
        EXC_INSTR_BUS_FAULT: save_hit[TRAP_BUSERR]  = 1'b1;
        default:             save_hit = '0;
      endcase
    end
  end

  assign capture = save_hit & ~found_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | capture;
    end
  end

  // First mepc written for each kind
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_TRAP_KINDS; k++) begin
      if (capture[k]) begin
        pc_q[k] <= mepc_n_i;
      end
    end
  end

  assign found_o = found_q;
  assign pc_o    = pc_q;

endmodule

`default_nettype wire

// File: mepc_checker.sv
// Compares only the first trap of each kind against the first matching mepc save
`timescale 1ns/1ns
`default_nettype none

module mepc_checker #(
  parameter int PC_W = monitor_cfg_pkg::PC_WIDTH
) (
  input  wire logic                     clk,
  input  wire logic                     rst_ni,
  input  wire logic                     wb_valid_i,
  input  wire logic [PC_W-1:0]          wb_pc_i,
  input  wire logic                     wb_illegal_i,
  input  wire logic                     wb_ecall_i,
  input  wire logic                     wb_ebrk_i,
  input  wire logic                     wb_bus_err_i,
  input  wire logic                     irq_ack_i,
  input  wire logic                     debug_req_i,
  input  wire logic                     nmi_trap_i,
  input  wire logic                     debug_entry_i,
  input  wire logic                     csr_save_cause_i,
  input  wire rv_trap_pkg::trap_cause_u csr_cause_i,
  input  wire logic [PC_W-1:0]          mepc_n_i,
  output rv_trap_pkg::kind_vec_t        mepc_err_o
);

  import rv_trap_pkg::*;

  kind_vec_t                            exp_found;
  kind_vec_t                            act_found;
  logic [NUM_TRAP_KINDS-1:0][PC_W-1:0]  exp_pc;
  logic [NUM_TRAP_KINDS-1:0][PC_W-1:0]  act_pc;
  kind_vec_t                            pc_differs;
  kind_vec_t                            mismatch;
  kind_vec_t                            err_q;

  ////////////////////////////////////////////////////////////////////////////
  // Expected side comes from writeback, actual side from the CSR write
  ////////////////////////////////////////////////////////////////////////////

  wb_trap_tracker #(
    .PC_W (PC_W)
  ) wb_trap_tracker_inst (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid_i),
    .wb_pc_i       (wb_pc_i),
    .wb_illegal_i  (wb_illegal_i),
    .wb_ecall_i    (wb_ecall_i),
    .wb_ebrk_i     (wb_ebrk_i),
    .wb_bus_err_i  (wb_bus_err_i),
    .irq_ack_i     (irq_ack_i),
    .debug_req_i   (debug_req_i),
    .nmi_trap_i    (nmi_trap_i),
    .debug_entry_i (debug_entry_i),
    .found_o       (exp_found),
    .pc_o          (exp_pc)
  );

  cause_save_tracker #(
    .PC_W (PC_W)
  ) cause_save_tracker_inst (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .csr_save_cause_i (csr_save_cause_i),
    .csr_cause_i      (csr_cause_i),
    .mepc_n_i         (mepc_n_i),
    .found_o          (act_found),
    .pc_o             (act_pc)
  );

  always_comb begin
    for (int k = 0; k < NUM_TRAP_KINDS; k++) begin
      pc_differs[k] = (exp_pc[k] != act_pc[k]);
    end
  end

  // Compare only once both captures of a kind exist, so payload before capture is ignored
  assign mismatch = exp_found & act_found & pc_differs;

  // Sticky flags, one edge after the later capture
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else begin
      err_q <= err_q | mismatch;
    end
  end

  assign mepc_err_o = err_q;

  // A flag may only rise if both trackers held a capture of that kind in the previous cycle
  a_err_needs_both : assert property (@(posedge clk) disable iff (!rst_ni)
    ((err_q & ~$past(err_q) & ~$past(exp_found & act_found)) == '0))
    else $error("mepc_checker: flag rose without both captures");

endmodule

`default_nettype wire

// File: step_retire_monitor.sv
// Counts retirements at writeback; interrupts taken while stepping are not modelled
`timescale 1ns/1ns
`default_nettype none

module step_retire_monitor (
  input  wire logic clk,
  input  wire logic rst_ni,
  input  wire logic wb_valid_i,
  input  wire logic step_i,
  input  wire logic debug_mode_i,
  output logic      step_err_o
);

  logic armed_q;
  logic err_q;

  // A stepped retirement outside debug mode arms the check
  // The next retirement consumes it and may arm it again
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      if (wb_valid_i) begin
        armed_q <= step_i && !debug_mode_i;
        // After one stepped instruction the core must already be halted in debug mode
        if (armed_q && (!debug_mode_i || !step_i)) begin
          err_q <= 1'b1;
        end
      end
    end
  end

  assign step_err_o = err_q;

  // Arming only ever comes from a retirement seen outside debug mode
  a_arm_outside_debug : assert property (@(posedge clk) disable iff (!rst_ni)
    $rose(armed_q) |-> $past(!debug_mode_i))
    else $error("step_retire_monitor: armed in debug mode");

endmodule

`default_nettype wire

// File: mem_attr_monitor.sv
// Fetch memtype is checked every cycle, so the core must hold it non-bufferable when idle too
`timescale 1ns/1ns
`default_nettype none

module mem_attr_monitor (
  input  wire logic                                   clk,
  input  wire logic                                   rst_ni,
  input  wire logic [monitor_cfg_pkg::MEMTYPE_WIDTH-1:0] instr_memtype_i,
  input  wire logic                                   data_req_i,
  input  wire logic                                   data_we_i,
  input  wire logic [monitor_cfg_pkg::MEMTYPE_WIDTH-1:0] data_memtype_i,
  output logic                                        fetch_buf_err_o,
  output logic                                        load_buf_err_o
);

  import monitor_cfg_pkg::*;

  logic fetch_buf_q;
  logic load_buf_q;

  // Stores may be buffered, fetches and loads never
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_buf_q <= 1'b0;
      load_buf_q  <= 1'b0;
    end else begin
      if (instr_memtype_i[MEMTYPE_BUFFERABLE_BIT]) begin
        fetch_buf_q <= 1'b1;
      end
      if (data_req_i && !data_we_i && data_memtype_i[MEMTYPE_BUFFERABLE_BIT]) begin
        load_buf_q <= 1'b1;
      end
    end
  end

  assign fetch_buf_err_o = fetch_buf_q;
  assign load_buf_err_o  = load_buf_q;

endmodule

`default_nettype wire

// File: core_monitor.sv
// Passive monitor; all probes are per-cycle levels, flags in err_o stay set until rst_ni
`timescale 1ns/1ns
`default_nettype none

module core_monitor #(
  parameter int PC_W = monitor_cfg_pkg::PC_WIDTH
) (
  input  wire logic                                      clk,
  input  wire logic                                      rst_ni,
  // Writeback probes
  input  wire logic                                      wb_valid_i,
  input  wire logic [PC_W-1:0]                           wb_pc_i,
  input  wire logic                                      wb_illegal_i,
  input  wire logic                                      wb_ecall_i,
  input  wire logic                                      wb_ebrk_i,
  input  wire logic                                      wb_bus_err_i,
  // Trap and debug control probes
  input  wire logic                                      irq_ack_i,
  input  wire logic                                      debug_req_i,
  input  wire logic                                      nmi_trap_i,
  input  wire logic                                      debug_entry_i,
  input  wire logic                                      csr_save_cause_i,
  input  wire rv_trap_pkg::trap_cause_u                  csr_cause_i,
  input  wire logic [PC_W-1:0]                           mepc_n_i,
  // Stepping probes
  input  wire logic                                      step_i,
  input  wire logic                                      debug_mode_i,
  // Bus attribute probes
  input  wire logic [monitor_cfg_pkg::MEMTYPE_WIDTH-1:0] instr_memtype_i,
  input  wire logic                                      data_req_i,
  input  wire logic                                      data_we_i,
  input  wire logic [monitor_cfg_pkg::MEMTYPE_WIDTH-1:0] data_memtype_i,
  output monitor_cfg_pkg::check_vec_t                    err_o
);

  import monitor_cfg_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Each monitor drives its own slice of err_o
  ////////////////////////////////////////////////////////////////////////////

  // The mepc flags sit at indices equal to the trap kind values
  mepc_checker #(
    .PC_W (PC_W)
  ) mepc_checker_inst (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .wb_valid_i       (wb_valid_i),
    .wb_pc_i          (wb_pc_i),
    .wb_illegal_i     (wb_illegal_i),
    .wb_ecall_i       (wb_ecall_i),
    .wb_ebrk_i        (wb_ebrk_i),
    .wb_bus_err_i     (wb_bus_err_i),
    .irq_ack_i        (irq_ack_i),
    .debug_req_i      (debug_req_i),
    .nmi_trap_i       (nmi_trap_i),
    .debug_entry_i    (debug_entry_i),
    .csr_save_cause_i (csr_save_cause_i),
    .csr_cause_i      (csr_cause_i),
    .mepc_n_i         (mepc_n_i),
    .mepc_err_o       (err_o[CHK_MEPC_BUSERR:CHK_MEPC_ILLEGAL])
  );

  step_retire_monitor step_retire_monitor_inst (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_valid_i   (wb_valid_i),
    .step_i       (step_i),
    .debug_mode_i (debug_mode_i),
    .step_err_o   (err_o[CHK_STEP])
  );

  mem_attr_monitor mem_attr_monitor_inst (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .instr_memtype_i (instr_memtype_i),
    .data_req_i      (data_req_i),
    .data_we_i       (data_we_i),
    .data_memtype_i  (data_memtype_i),
    .fetch_buf_err_o (err_o[CHK_FETCH_BUF]),
    .load_buf_err_o  (err_o[CHK_LOAD_BUF])
  );

endmodule

`default_nettype wire

// File: tb_core_monitor.sv
// Reads core_monitor_cases.txt from the working directory and assumes the default PC width of 32
`timescale 1ns/1ns
`default_nettype none

module tb_core_monitor;

  import monitor_cfg_pkg::*;
  import rv_trap_pkg::*;

  logic                     clk;
  logic                     rst_ni;
  logic                     wb_valid_i;
  logic [PC_WIDTH-1:0]      wb_pc_i;
  logic                     wb_illegal_i;
  logic                     wb_ecall_i;
  logic                     wb_ebrk_i;
  logic                     wb_bus_err_i;
  logic                     irq_ack_i;
  logic                     debug_req_i;
  logic                     nmi_trap_i;
  logic                     debug_entry_i;
  logic                     csr_save_cause_i;
  trap_cause_u              csr_cause_i;
  logic [PC_WIDTH-1:0]      mepc_n_i;
  logic                     step_i;
  logic                     debug_mode_i;
  logic [MEMTYPE_WIDTH-1:0] instr_memtype_i;
  logic                     data_req_i;
  logic                     data_we_i;
  logic [MEMTYPE_WIDTH-1:0] data_memtype_i;
  check_vec_t               err_o;

  // Every queue holds one entry per case line
  logic [4:0]                       wb_q[$];
  logic [4:0]                       ctl_q[$];
  logic [1:0]                       stp_q[$];
  logic [5:0]                       bus_q[$];
  logic [PC_WIDTH-1:0]              pc_q[$];
  logic [$bits(trap_cause_u)-1:0]   cause_q[$];
  logic [PC_WIDTH-1:0]              mepc_q[$];
  check_vec_t                       exp_q[$];

  int     num_cases;
  bit     cases_loaded;
  integer seed = 32'h211d_dd17;

  core_monitor #(
    .PC_W (PC_WIDTH)
  ) core_monitor_inst (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .wb_valid_i       (wb_valid_i),
    .wb_pc_i          (wb_pc_i),
    .wb_illegal_i     (wb_illegal_i),
    .wb_ecall_i       (wb_ecall_i),
    .wb_ebrk_i        (wb_ebrk_i),
    .wb_bus_err_i     (wb_bus_err_i),
    .irq_ack_i        (irq_ack_i),
    .debug_req_i      (debug_req_i),
    .nmi_trap_i       (nmi_trap_i),
    .debug_entry_i    (debug_entry_i),
    .csr_save_cause_i (csr_save_cause_i),
    .csr_cause_i      (csr_cause_i),
    .mepc_n_i         (mepc_n_i),
    .step_i           (step_i),
    .debug_mode_i     (debug_mode_i),
    .instr_memtype_i  (instr_memtype_i),
    .data_req_i       (data_req_i),
    .data_we_i        (data_we_i),
    .data_memtype_i   (data_memtype_i),
    .err_o            (err_o)
  );

  // The 10 ns clock has its rising edges at 5, 15, 25 ns and so on
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_vec(input check_vec_t got, input check_vec_t want, input int idx);
    if (got !== want) begin
      $display("[ERROR] %0t err_o got %b expected %b (case %0d)", $time, got, want, idx);
      abort_run();
    end
  endtask

  // Every line that is not blank and not a # comment holds eight columns
  task automatic load_cases(output bit ok);
    int                             fd;
    int                             n;
    string                          line;
    logic [4:0]                     wb;
    logic [4:0]                     ctl;
    logic [1:0]                     stp;
    logic [5:0]                     bus;
    logic [PC_WIDTH-1:0]            pc;
    logic [$bits(trap_cause_u)-1:0] cause;
    logic [PC_WIDTH-1:0]            mepc;
    check_vec_t                     want;
    ok = 1'b1;
    fd = $fopen("core_monitor_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file core_monitor_cases.txt");
      ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
          continue;
        end
        n = $sscanf(line, "%b %b %b %b %h %h %h %b", wb, ctl, stp, bus, pc, cause, mepc, want);
        if (n != 8) begin
          $display("Malformed line in the case file after %0d cases", wb_q.size());
          ok = 1'b0;
          break;
        end
        wb_q.push_back(wb);
        ctl_q.push_back(ctl);
        stp_q.push_back(stp);
        bus_q.push_back(bus);
        pc_q.push_back(pc);
        cause_q.push_back(cause);
        mepc_q.push_back(mepc);
        exp_q.push_back(want);
      end
      $fclose(fd);
      num_cases = wb_q.size();
      if (ok && num_cases == 0) begin
        $display("The case file holds no cases");
        ok = 1'b0;
      end
    end
  endtask

  task automatic init_inputs();
    rst_ni           = 1'b0;
    wb_valid_i       = 1'b0;
    wb_pc_i          = '0;
    wb_illegal_i     = 1'b0;
    wb_ecall_i       = 1'b0;
    wb_ebrk_i        = 1'b0;
    wb_bus_err_i     = 1'b0;
    irq_ack_i        = 1'b0;
    debug_req_i      = 1'b0;
    nmi_trap_i       = 1'b0;
    debug_entry_i    = 1'b0;
    csr_save_cause_i = 1'b0;
    csr_cause_i      = '0;
    mepc_n_i         = '0;
    step_i           = 1'b0;
    debug_mode_i     = 1'b0;
    instr_memtype_i  = '0;
    data_req_i       = 1'b0;
    data_we_i        = 1'b0;
    data_memtype_i   = '0;
  endtask

  // Drives one case line
  // A cycle without retirement gets a random PC that must not matter
  task automatic apply_case(input int i);
    wb_valid_i       = wb_q[i][4];
    wb_illegal_i     = wb_q[i][3];
    wb_ecall_i       = wb_q[i][2];
    wb_ebrk_i        = wb_q[i][1];
    wb_bus_err_i     = wb_q[i][0];
    irq_ack_i        = ctl_q[i][4];
    debug_req_i      = ctl_q[i][3];
    nmi_trap_i       = ctl_q[i][2];
    debug_entry_i    = ctl_q[i][1];
    csr_save_cause_i = ctl_q[i][0];
    step_i           = stp_q[i][1];
    debug_mode_i     = stp_q[i][0];
    instr_memtype_i  = bus_q[i][5:4];
    data_req_i       = bus_q[i][3];
    data_we_i        = bus_q[i][2];
    data_memtype_i   = bus_q[i][1:0];
    // Interrupt saves are built through the interrupt view from the id in the low bits
    if (cause_q[i][$bits(trap_cause_u)-1]) begin
      csr_cause_i.irq.interrupt = 1'b1;
      csr_cause_i.irq.unused    = '0;
      csr_cause_i.irq.irq_id    = cause_q[i][IRQ_ID_WIDTH-1:0];
    end else begin
      csr_cause_i = cause_q[i];
    end
    mepc_n_i         = mepc_q[i];
    if (wb_q[i][4]) begin
      wb_pc_i = pc_q[i];
    end else begin
      wb_pc_i = $random(seed);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    bit ok;
    clk          = 1'b0;
    cases_loaded = 1'b0;
    init_inputs();
    load_cases(ok);
    if (!ok) begin
      abort_run();
    end else begin
      cases_loaded = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      // Flags must be clear while reset is still applied
      check_vec(err_o, '0, -1);
      rst_ni = 1'b1;
      // Inputs change on falling edges and err_o for a line is read one cycle later
      for (int i = 0; i < num_cases; i++) begin
        apply_case(i);
        @(negedge clk);
        check_vec(err_o, exp_q[i], i);
      end
      $display("All checks passed");
      $finish;
    end
  end

  // Limit is the case count plus ten cycles for reset and slack
  initial begin : watchdog
    wait (cases_loaded);
    #((num_cases + 10) * 10);
    $display("Timeout after %0d cycles without reaching the end of the cases", num_cases + 10);
    abort_run();
  end

endmodule

`default_nettype wire

// File: core_monitor_cases.txt
# wb: valid illegal ecall ebrk bus_err | ctl: irq_ack debug_req nmi debug_entry save_cause
# stp: step debug_mode | bus: imem[1:0] req we dmem[1:0] | pc cause mepc (hex) | err_o next cycle
00000 00000 00 000000 00000000 000 00000000 0000000  idle after reset
00000 00000 00 000000 00000000 000 00000000 0000000
10001 10000 00 000000 000002f0 000 00000000 0000000  bus error under irq_ack is not a trap
11001 00000 00 000000 00000300 000 00000000 0000000  bus error wins over illegal
00000 00001 00 000000 00000000 001 00000300 0000000  bus fault save matches
00000 00001 00 000000 00000000 802 00000999 0000000  interrupt view with id 2 is ignored
11000 00000 00 000000 00000100 000 00000000 0000000  illegal at A
00000 00001 00 000000 00000000 002 00000100 0000000  mepc A
00000 00000 00 000000 00000000 000 00000000 0000000  no illegal or bus error flag
10100 00000 00 000000 00000200 000 00000000 0000000  ecall at B
00000 00001 00 000000 00000000 00b 00000204 0000000  mepc B+4
00000 00000 00 000000 00000000 000 00000000 0000010  ecall mismatch visible
10010 00010 00 000000 00000400 000 00000000 0000010  ebreak entering debug is captured
00000 00001 00 000000 00000000 003 00000404 0000010
00000 00000 00 000000 00000000 000 00000000 0000110  ebreak mismatch visible
10000 00000 10 000000 00000500 000 00000000 0000110  stepped retirement
00000 00000 00 000000 00000000 000 00000000 0000110
10000 00000 11 000000 00000504 000 00000000 0000110  next retirement halted in debug
10000 00000 10 000000 00000508 000 00000000 0000110  stepped retirement
10000 00000 10 000000 0000050c 000 00000000 0010110  next retirement outside debug
00000 00000 00 001010 00000000 000 00000000 0010110  load with only memtype bit 1
00000 00000 00 001101 00000000 000 00000000 0010110  bufferable store
00000 00000 00 001001 00000000 000 00000000 1010110  bufferable load
00000 00000 00 010000 00000000 000 00000000 1110110  bufferable fetch
00000 00000 00 000000 00000000 000 00000000 1110110
00000 00000 00 000000 00000000 000 00000000 1110110

// File: verilog.f
monitor_cfg_pkg.sv
rv_trap_pkg.sv
wb_trap_tracker.sv
cause_save_tracker.sv
mepc_checker.sv
step_retire_monitor.sv
mem_attr_monitor.sv
core_monitor.sv
tb_core_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f verilog.f --top-module tb_core_monitor -Mdir obj_dir -o sim_core_monitor
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_core_monitor > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"
exit 0
